// File: vlog.f
ref_feed_pkg.sv
ref_feed_fsm.sv
target_info.sv
base_shifter.sv
feed_debug_regs.sv
ref_feed_top.sv
tb_ref_feed_top.sv

// File: tb_ref_feed_top.sv
// target feeder testbench
`timescale 1ns/100ps

module tb_ref_feed_top import ref_feed_pkg::*;;

    localparam int TIMEOUT_CYCLES = 4000;

    logic                      clk;
    logic                      rst;
    logic                      s1i_valid;
    stream_word_t              s1i_data;
    logic                      s1i_ready;
    logic [BASE_W-1:0]         s1o_data;
    logic                      s1o_valid;
    logic                      s1o_ready;
    logic                      s1o_last;
    logic                      s1o_start;
    logic signed [SCORE_W-1:0] s1o_score;
    logic                      reg_rd;
    logic [REG_ADDR_W-1:0]     reg_addr;
    logic [31:0]               reg_data;

    integer seed;
    int     errors;
    int     checks;
    int     cycles;
    // totals sent so far, compared against the debug counters
    int     n_targets;
    int     n_words;
    int     n_bases;

    // monitor capture for the target under test
    logic [BASE_W-1:0] got_bases[$];
    bit                got_last[$];
    int                start_pos[$];
    int                start_score[$];
    bit                target_done;

    ref_feed_top u_ref_feed_top (
        .clk(clk), .rst(rst),
        .s1i_valid(s1i_valid), .s1i_data(s1i_data), .s1i_ready(s1i_ready),
        .s1o_data(s1o_data), .s1o_valid(s1o_valid), .s1o_ready(s1o_ready),
        .s1o_last(s1o_last), .s1o_start(s1o_start), .s1o_score(s1o_score),
        .reg_rd(reg_rd), .reg_addr(reg_addr), .reg_data(reg_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////
    // monitor and timeout
    //////////////////////////////

    // outputs are sampled on the rising edge, before the state moves on
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (!rst) begin
            if (s1o_valid) begin
                got_bases.push_back(s1o_data);
                got_last.push_back(s1o_last);
            end
            // base index at the pulse shows whether start came first
            if (s1o_start) begin
                start_pos.push_back(got_bases.size());
                start_score.push_back(int'(s1o_score));
            end
            if (s1o_valid && s1o_last)
                target_done = 1'b1;
        end
        if (cycles == TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the feeder stopped responding", cycles);
            $display("tests failed");
            $finish;
        end
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic check_value(input string name, input int expected, input int actual);
        checks++;
        if (expected !== actual) begin
            $display("Fail %s: expected %0d, actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    // hold the word until the FSM takes it, the transfer is on the next rising edge
    task automatic send_word(input stream_word_t w);
        @(negedge clk);
        s1i_valid = 1'b1;
        s1i_data  = w;
        while (!s1i_ready)
            @(negedge clk);
        @(negedge clk);
        s1i_valid = 1'b0;
    endtask

    // one target: header, optional array stall, then random data words
    task automatic run_target(input string name, input int len, input int score,
                              input int hold);
        stream_word_t      w;
        logic [BASE_W-1:0] exp_bases[$];
        int                words;
        got_bases.delete();
        got_last.delete();
        start_pos.delete();
        start_score.delete();
        target_done = 1'b0;
        words = (len + BASES_PER_WORD - 1) / BASES_PER_WORD;
        if (hold > 0) begin
            @(negedge clk);
            s1o_ready = 1'b0;
        end
        w            = '0;
        w.hdr.length = len[T_POS_W-1:0];
        w.hdr.score  = score[SCORE_W-1:0];
        send_word(w);
        if (hold > 0) begin
            repeat (hold) @(negedge clk);
            if (start_pos.size() != 0 || got_bases.size() != 0) begin
                $display("%s: start or bases came out while the array was not ready", name);
                errors++;
            end
            s1o_ready = 1'b1;
        end
        for (int k = 0; k < words; k++) begin
            w = {$random(seed), $random(seed), $random(seed), $random(seed)};
            // low base of the data view leaves first
            for (int i = 0; i < BASES_PER_WORD && exp_bases.size() < len; i++)
                exp_bases.push_back(w.bases[i]);
            send_word(w);
        end
        while (!target_done)
            @(negedge clk);
        check_value({name, " base count"}, len, got_bases.size());
        for (int i = 0; i < len && i < got_bases.size(); i++) begin
            check_value($sformatf("%s base %0d", name, i), exp_bases[i], got_bases[i]);
            check_value($sformatf("%s last %0d", name, i), int'(i == len - 1), got_last[i]);
        end
        check_value({name, " start pulses"}, 1, start_pos.size());
        if (start_pos.size() == 1) begin
            check_value({name, " bases before start"}, 0, start_pos[0]);
            check_value({name, " score at start"}, score, start_score[0]);
        end
        n_targets += 1;
        n_words   += words;
        n_bases   += len;
    endtask

    task automatic read_reg(input logic [REG_ADDR_W-1:0] addr, output int data);
        @(negedge clk);
        reg_rd   = 1'b1;
        reg_addr = addr;
        @(negedge clk);
        reg_rd = 1'b0;
        data   = reg_data;
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////

    task automatic test_short();
        run_target("short", 5, 37, 0);
    endtask

    // 150 bases span three words, the last one partly filled
    task automatic test_multi_word();
        run_target("multi word", 150, -12, 0);
    endtask

    // score extremes, sign included
    task automatic test_start_score();
        run_target("score min", 20, -256, 0);
        run_target("score max", 30, 255, 0);
    endtask

    task automatic test_start_gating();
        run_target("start gating", 10, -1, 10);
    endtask

    task automatic test_back_to_back();
        run_target("length one", 1, 3, 0);
        run_target("full word", 64, -77, 0);
    endtask

    task automatic test_debug_regs();
        int v;
        read_reg(REG_VERSION, v);
        check_value("regs version", 1, v);
        read_reg(REG_TARGETS, v);
        check_value("regs targets", n_targets, v);
        read_reg(REG_LOADS, v);
        check_value("regs loads", n_words, v);
        read_reg(REG_BASES, v);
        check_value("regs bases", n_bases, v);
        read_reg(REG_STARTS, v);
        check_value("regs starts", n_targets, v);
        read_reg(REG_LASTS, v);
        check_value("regs lasts", n_targets, v);
        // unmapped index
        read_reg(4'd12, v);
        check_value("regs index 12", 0, v);
    endtask

    initial begin
        seed      = 32'ha4ca5a7d;
        errors    = 0;
        checks    = 0;
        cycles    = 0;
        n_targets = 0;
        n_words   = 0;
        n_bases   = 0;
        rst       = 1'b1;
        s1i_valid = 1'b0;
        s1i_data  = '0;
        s1o_ready = 1'b1;
        reg_rd    = 1'b0;
        reg_addr  = '0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        test_short();
        test_multi_word();
        test_start_score();
        test_start_gating();
        test_back_to_back();
        test_debug_regs();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: ref_feed_top.sv
// target base feeder top
`timescale 1ns/100ps

module ref_feed_top import ref_feed_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    // target stream in
    input  logic                      s1i_valid,
    input  stream_word_t              s1i_data,
    output logic                      s1i_ready,
    // bases out to the systolic array
    output logic [BASE_W-1:0]         s1o_data,
    output logic                      s1o_valid,
    input  logic                      s1o_ready,
    output logic                      s1o_last,
    output logic                      s1o_start,
    output logic signed [SCORE_W-1:0] s1o_score,
    // debug read port
    input  logic                      reg_rd,
    input  logic [REG_ADDR_W-1:0]     reg_addr,
    output logic [31:0]               reg_data
);

    feed_ctrl_t         ctrl;
    feed_state_t        state;
    logic [T_POS_W-1:0] length;
    logic [T_POS_W-1:0] bases_left;
    logic [T_POS_W-1:0] in_shifter;

    ref_feed_fsm u_ref_feed_fsm (
        .clk(clk), .rst(rst),
        .s1i_valid(s1i_valid), .s1i_ready(s1i_ready), .s1o_ready(s1o_ready),
        .bases_left(bases_left), .in_shifter(in_shifter), .ctrl(ctrl),
        .s1o_valid(s1o_valid), .s1o_start(s1o_start), .s1o_last(s1o_last),
        .state(state)
    );

    target_info u_target_info (
        .clk(clk), .rst(rst), .s1i_data(s1i_data), .ctrl(ctrl),
        .length(length), .bases_left(bases_left), .s1o_score(s1o_score)
    );

    base_shifter u_base_shifter (
        .clk(clk), .rst(rst), .s1i_data(s1i_data), .ctrl(ctrl),
        .bases_left(bases_left), .in_shifter(in_shifter), .s1o_data(s1o_data)
    );

    feed_debug_regs u_feed_debug_regs (
        .clk(clk), .rst(rst), .ctrl(ctrl), .state(state),
        .s1i_valid(s1i_valid), .s1i_ready(s1i_ready),
        .s1o_valid(s1o_valid), .s1o_ready(s1o_ready),
        .s1o_start(s1o_start), .s1o_last(s1o_last),
        .length(length), .bases_left(bases_left), .in_shifter(in_shifter),
        .reg_rd(reg_rd), .reg_addr(reg_addr), .reg_data(reg_data)
    );

endmodule

// File: feed_debug_regs.sv
// feeder debug counters and read port
`timescale 1ns/100ps

module feed_debug_regs import ref_feed_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  feed_ctrl_t            ctrl,
    input  feed_state_t           state,
    input  logic                  s1i_valid,
    input  logic                  s1i_ready,
    input  logic                  s1o_valid,
    input  logic                  s1o_ready,
    input  logic                  s1o_start,
    input  logic                  s1o_last,
    input  logic [T_POS_W-1:0]    length,
    input  logic [T_POS_W-1:0]    bases_left,
    input  logic [T_POS_W-1:0]    in_shifter,
    input  logic                  reg_rd,
    input  logic [REG_ADDR_W-1:0] reg_addr,
    output logic [31:0]           reg_data
);

    logic [CNT_W-1:0] cnt_targets;
    logic [CNT_W-1:0] cnt_loads;
    logic [CNT_W-1:0] cnt_bases;
    logic [CNT_W-1:0] cnt_starts;
    logic [CNT_W-1:0] cnt_lasts;
    feed_status_t     status_now;
    feed_status_t     status_q;

    //////////////////////////////
    // event counters
    //////////////////////////////

    // header and data loads already carry the transfer condition
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_targets <= '0;
            cnt_loads   <= '0;
            cnt_bases   <= '0;
            cnt_starts  <= '0;
            cnt_lasts   <= '0;
        end else begin
            if (ctrl.load_info)
                cnt_targets <= cnt_targets + 1'b1;
            if (ctrl.load_data)
                cnt_loads <= cnt_loads + 1'b1;
            if (s1o_valid)
                cnt_bases <= cnt_bases + 1'b1;
            if (s1o_start)
                cnt_starts <= cnt_starts + 1'b1;
            if (s1o_valid && s1o_last)
                cnt_lasts <= cnt_lasts + 1'b1;
        end
    end

    // live snapshot of the handshake and control lines
    always_comb begin
        status_now             = '0;
        status_now.state       = state;
        status_now.ctrl        = ctrl;
        status_now.in_valid    = s1i_valid;
        status_now.in_ready    = s1i_ready;
        status_now.out_valid   = s1o_valid;
        status_now.array_ready = s1o_ready;
        status_now.start       = s1o_start;
        status_now.last        = s1o_last;
    end

    //////////////////////////////
    // read port
    //////////////////////////////

    // reg_data is zero except the cycle after a read strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            status_q <= '0;
            reg_data <= '0;
        end else begin
            status_q <= status_now;
            reg_data <= '0;
            if (reg_rd) begin
                case (reg_addr)
                    REG_VERSION:  reg_data <= FEED_VERSION;
                    REG_TARGETS:  reg_data <= cnt_targets;
                    REG_LOADS:    reg_data <= cnt_loads;
                    REG_STATUS:   reg_data <= status_q;
                    REG_BASES:    reg_data <= cnt_bases;
                    REG_LENGTH:   reg_data <= 32'(length);
                    REG_LEFT:     reg_data <= 32'(bases_left);
                    REG_IN_SHIFT: reg_data <= 32'(in_shifter);
                    REG_STARTS:   reg_data <= cnt_starts;
                    REG_LASTS:    reg_data <= cnt_lasts;
                    default:      reg_data <= '0;
                endcase
            end
        end
    end

endmodule

// File: base_shifter.sv
// parallel load base shifter
`timescale 1ns/100ps

module base_shifter import ref_feed_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  stream_word_t       s1i_data,
    input  feed_ctrl_t         ctrl,
    input  logic [T_POS_W-1:0] bases_left,
    output logic [T_POS_W-1:0] in_shifter,
    output logic [BASE_W-1:0]  s1o_data
);

    logic [BASES_PER_WORD-1:0][BASE_W-1:0] bases_q;

    // base payload, low base leaves first
    always_ff @(posedge clk) begin
        if (ctrl.load_data) begin
            bases_q <= s1i_data.bases;
        end else if (ctrl.shift_data) begin
            bases_q <= bases_q >> BASE_W;
        end
    end

    assign s1o_data = bases_q[0];

    //////////////////////////////
    // valid base count
    //////////////////////////////

    // a short tail only fills part of the word
    always_ff @(posedge clk) begin
        if (rst) begin
            in_shifter <= '0;
        end else if (ctrl.load_data) begin
            if (bases_left >= BASES_PER_WORD) begin
                in_shifter <= T_POS_W'(BASES_PER_WORD);
            end else begin
                in_shifter <= bases_left;
            end
        end else if (ctrl.shift_data) begin
            in_shifter <= in_shifter - 1'b1;
        end
    end

    // the FSM must reload before the word runs dry
    a_no_empty_shift: assert property (@(posedge clk) disable iff (rst)
        ctrl.shift_data |-> in_shifter != '0);

endmodule

// File: target_info.sv
// target header capture
`timescale 1ns/100ps

module target_info import ref_feed_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  stream_word_t              s1i_data,
    input  feed_ctrl_t                ctrl,
    output logic [T_POS_W-1:0]        length,
    output logic [T_POS_W-1:0]        bases_left,
    output logic signed [SCORE_W-1:0] s1o_score
);

    header_t hdr;

    // header view of the stream word
    assign hdr = s1i_data.hdr;

    // length and prior score, held until the next header
    always_ff @(posedge clk) begin
        if (rst) begin
            length    <= '0;
            s1o_score <= '0;
        end else if (ctrl.load_info) begin
            length    <= hdr.length;
            s1o_score <= hdr.score;
        end
    end

    //////////////////////////////
    // bases still to send
    //////////////////////////////

    // loaded straight from the header, one less per base shifted out
    always_ff @(posedge clk) begin
        if (rst) begin
            bases_left <= '0;
        end else if (ctrl.load_info) begin
            bases_left <= hdr.length;
        end else if (ctrl.shift_data) begin
            bases_left <= bases_left - 1'b1;
        end
    end

endmodule

// File: ref_feed_fsm.sv
// target feeder control FSM
`timescale 1ns/100ps

module ref_feed_fsm import ref_feed_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               s1i_valid,
    output logic               s1i_ready,
    input  logic               s1o_ready,
    input  logic [T_POS_W-1:0] bases_left,
    input  logic [T_POS_W-1:0] in_shifter,
    output feed_ctrl_t         ctrl,
    output logic               s1o_valid,
    output logic               s1o_start,
    output logic               s1o_last,
    output feed_state_t        state
);

    feed_state_t next_state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= INFO;
        end else begin
            state <= next_state;
        end
    end

    //////////////////////////////
    // next state and strobes
    //////////////////////////////

    always_comb begin
        next_state = state;
        ctrl       = '0;
        s1i_ready  = 1'b0;
        s1o_valid  = 1'b0;
        s1o_start  = 1'b0;
        s1o_last   = 1'b0;
        case (state)
            // wait for a header word
            INFO: begin
                s1i_ready      = 1'b1;
                ctrl.load_info = s1i_valid;
                if (s1i_valid) begin
                    next_state = START;
                end
            end
            // the array must be ready before the start pulse
            START: begin
                if (s1o_ready) begin
                    s1o_start  = 1'b1;
                    next_state = LOAD;
                end
            end
            // fetch the next data word, no base goes out here
            LOAD: begin
                s1i_ready      = 1'b1;
                ctrl.load_data = s1i_valid;
                if (s1i_valid) begin
                    // a single base left is sent straight from LAST
                    next_state = (bases_left == 1) ? LAST : SHIFT;
                end
            end
            SHIFT: begin
                s1o_valid       = 1'b1;
                ctrl.shift_data = 1'b1;
                // an empty shifter wins, the final base may sit in the next word
                if (in_shifter == 1) begin
                    next_state = LOAD;
                end else if (bases_left == 2) begin
                    next_state = LAST;
                end
            end
            // final base of the target, shifter is not advanced
            LAST: begin
                s1o_valid  = 1'b1;
                s1o_last   = 1'b1;
                next_state = INFO;
            end
            default: next_state = INFO;
        endcase
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    // last only ever marks a valid base
    a_last_valid: assert property (@(posedge clk) disable iff (rst)
        s1o_last |-> s1o_valid);

    // start comes ahead of the bases, never alongside one
    a_start_no_valid: assert property (@(posedge clk) disable iff (rst)
        s1o_start |-> !s1o_valid ##1 !s1o_valid);

endmodule

// File: ref_feed_pkg.sv
// target feeder shared definitions
package ref_feed_pkg;

    //////////////////////////////
    // widths and counts
    //////////////////////////////

    localparam int BASE_W         = 2;
    localparam int STREAM_W       = 128;
    localparam int BASES_PER_WORD = STREAM_W / BASE_W;
    // enough for a target length or a base index
    localparam int T_POS_W        = 9;
    localparam int SCORE_W        = 9;
    // score field starts here inside a header word
    localparam int SCORE_LSB      = 16;
    localparam int CNT_W          = 32;
    localparam logic [31:0] FEED_VERSION = 32'h0000_0001;

    //////////////////////////////
    // register map
    //////////////////////////////

    localparam int REG_ADDR_W = 4;
    localparam logic [REG_ADDR_W-1:0] REG_VERSION   = 4'd0;
    localparam logic [REG_ADDR_W-1:0] REG_TARGETS   = 4'd1;
    localparam logic [REG_ADDR_W-1:0] REG_LOADS     = 4'd2;
    localparam logic [REG_ADDR_W-1:0] REG_STATUS    = 4'd3;
    localparam logic [REG_ADDR_W-1:0] REG_BASES     = 4'd4;
    localparam logic [REG_ADDR_W-1:0] REG_LENGTH    = 4'd5;
    localparam logic [REG_ADDR_W-1:0] REG_LEFT      = 4'd6;
    localparam logic [REG_ADDR_W-1:0] REG_IN_SHIFT  = 4'd7;
    localparam logic [REG_ADDR_W-1:0] REG_STARTS    = 4'd8;
    localparam logic [REG_ADDR_W-1:0] REG_LASTS     = 4'd9;

    //////////////////////////////
    // types
    //////////////////////////////

    // header layout, length in the low bits and signed prior score above it
    typedef struct packed {
        logic [STREAM_W-SCORE_LSB-SCORE_W-1:0] pad_hi;
        logic signed [SCORE_W-1:0]             score;
        logic [SCORE_LSB-T_POS_W-1:0]          pad_lo;
        logic [T_POS_W-1:0]                    length;
    } header_t;

    // one stream word is either a header or 64 packed bases
    typedef union packed {
        header_t                                hdr;
        logic [BASES_PER_WORD-1:0][BASE_W-1:0] bases;
    } stream_word_t;

    typedef struct packed {
        logic load_info;
        logic load_data;
        logic shift_data;
    } feed_ctrl_t;

    typedef enum logic [2:0] {
        INFO  = 3'd0,
        START = 3'd1,
        LOAD  = 3'd2,
        SHIFT = 3'd3,
        LAST  = 3'd4
    } feed_state_t;

    // status snapshot, state in the top bits
    typedef struct packed {
        feed_state_t state;
        feed_ctrl_t  ctrl;
        logic        in_valid;
        logic        in_ready;
        logic        out_valid;
        logic        array_ready;
        logic        start;
        logic        last;
        logic [19:0] pad;
    } feed_status_t;

endpackage
